//--- line_io_settings.svh
`ifndef LINE_IO_SETTINGS_SVH
`define LINE_IO_SETTINGS_SVH

// ----------------------------------------------------------
// digital i/o block sizing
// ----------------------------------------------------------

// output lines driven by the selector
`define LINE_COUNT          3
// user output levels set by software
`define USER_OUTPUT_COUNT   3

// apb slave bus widths
`define APB_ADDR_WIDTH      8
`define APB_DATA_WIDTH      32

// strobe delay and width counters, in clk cycles
`define STROBE_COUNT_WIDTH  16

`endif

//--- line_io_pkg.sv
`include "line_io_settings.svh"

package line_io_pkg;

	// ----------------------------------------------------------
	// line routing types
	// ----------------------------------------------------------

	// source code per line
	// 1 strobe, 2..4 user output 0..2, anything else user output 0
	typedef logic [2:0] line_source_t;

	// one bit per output line, also the inversion mask
	typedef logic [`LINE_COUNT-1:0] line_vec_t;

	// one bit per user output level
	typedef logic [`USER_OUTPUT_COUNT-1:0] user_level_t;

	// ----------------------------------------------------------
	// apb bus types
	// ----------------------------------------------------------

	typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

	// ----------------------------------------------------------
	// strobe generator types
	// ----------------------------------------------------------

	// delay and width in clk cycles
	typedef logic [`STROBE_COUNT_WIDTH-1:0] strobe_count_t;

	// flash pulse sequencing
	typedef enum logic [1:0] {
		st_idle,
		st_delay,
		st_active
	} strobe_state_t;

endpackage

//--- line_io_regs.sv
`timescale 1ns/1ps

module line_io_regs (
	input  logic                      clk,
	input  logic                      rst_n,
	// apb slave
	input  line_io_pkg::apb_addr_t    paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  line_io_pkg::apb_data_t    pwdata,
	output line_io_pkg::apb_data_t    prdata,
	output logic                      pready,
	output logic                      pslverr,
	// status sources
	input  logic                      strobe_busy,
	input  line_io_pkg::line_vec_t    line_out,
	// configuration
	output line_io_pkg::user_level_t  user_level,
	output line_io_pkg::line_source_t line_source1,
	output line_io_pkg::line_source_t line_source2,
	output line_io_pkg::line_source_t line_source3,
	output line_io_pkg::line_vec_t    line_invert,
	output line_io_pkg::strobe_count_t strobe_delay,
	output line_io_pkg::strobe_count_t strobe_width
);

	import line_io_pkg::*;

	// ----------------------------------------------------------
	// register map
	// ----------------------------------------------------------

	localparam apb_addr_t addr_user_level   = 'h00;
	localparam apb_addr_t addr_line_source1 = 'h04;
	localparam apb_addr_t addr_line_source2 = 'h08;
	localparam apb_addr_t addr_line_source3 = 'h0C;
	localparam apb_addr_t addr_line_invert  = 'h10;
	localparam apb_addr_t addr_strobe_delay = 'h14;
	localparam apb_addr_t addr_strobe_width = 'h18;
	// read-only
	localparam apb_addr_t addr_status       = 'h1C;

	// access phase of a transfer
	logic      access;
	// paddr hits a mapped register
	logic      addr_hit;
	// read value before the error gate
	apb_data_t read_word;

	assign access = psel & penable;

	// zero wait states, every access completes at once
	assign pready = 1'b1;

	// ----------------------------------------------------------
	// address decode and read mux
	// ----------------------------------------------------------

	always_comb begin
		addr_hit  = 1'b1;
		read_word = '0;
		case (paddr)
			addr_user_level:   read_word = apb_data_t'(user_level);
			addr_line_source1: read_word = apb_data_t'(line_source1);
			addr_line_source2: read_word = apb_data_t'(line_source2);
			addr_line_source3: read_word = apb_data_t'(line_source3);
			addr_line_invert:  read_word = apb_data_t'(line_invert);
			addr_strobe_delay: read_word = apb_data_t'(strobe_delay);
			addr_strobe_width: read_word = apb_data_t'(strobe_width);
			// bit 0 busy, bits 3:1 live line outputs
			addr_status:       read_word = apb_data_t'({line_out, strobe_busy});
			default: begin
				addr_hit  = 1'b0;
				read_word = '0;
			end
		endcase
	end

	// unmapped addresses read back as 0
	assign prdata = read_word;

	// error only in the access phase of an unmapped transfer
	assign pslverr = access & ~addr_hit;

	// ----------------------------------------------------------
	// configuration registers
	// ----------------------------------------------------------

	// write lands on the edge closing the access phase
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			user_level   <= '0;
			line_source1 <= '0;
			line_source2 <= '0;
			line_source3 <= '0;
			line_invert  <= '0;
			strobe_delay <= '0;
			// one cycle flash by default
			strobe_width <= strobe_count_t'(1);
		end else if (access && pwrite) begin
			// upper pwdata bits dropped by the narrowing casts
			case (paddr)
				addr_user_level:   user_level   <= user_level_t'(pwdata);
				addr_line_source1: line_source1 <= line_source_t'(pwdata);
				addr_line_source2: line_source2 <= line_source_t'(pwdata);
				addr_line_source3: line_source3 <= line_source_t'(pwdata);
				addr_line_invert:  line_invert  <= line_vec_t'(pwdata);
				addr_strobe_delay: strobe_delay <= strobe_count_t'(pwdata);
				addr_strobe_width: strobe_width <= strobe_count_t'(pwdata);
				// status and unmapped writes change nothing
				default: ;
			endcase
		end
	end

endmodule

//--- strobe_pulse_gen.sv
`timescale 1ns/1ps

module strobe_pulse_gen (
	input  logic                       clk,
	input  logic                       rst_n,
	// level from the sensor
	input  logic                       exposure_start,
	// timing from the register file
	input  line_io_pkg::strobe_count_t strobe_delay,
	input  line_io_pkg::strobe_count_t strobe_width,
	// flash pulse and sequencer activity
	output logic                       strobe,
	output logic                       strobe_busy
);

	import line_io_pkg::*;

	// ----------------------------------------------------------
	// exposure edge detect
	// ----------------------------------------------------------

	// exposure_start sampled this edge and the one before
	logic          exp_q1;
	logic          exp_q2;
	// rising edge seen on the last sample
	logic          exp_rise;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_q1 <= 1'b0;
			exp_q2 <= 1'b0;
		end else begin
			exp_q1 <= exposure_start;
			exp_q2 <= exp_q1;
		end
	end

	assign exp_rise = exp_q1 & ~exp_q2;

	// ----------------------------------------------------------
	// delay / width sequencer
	// ----------------------------------------------------------

	strobe_state_t state;
	// remaining cycles in the current phase, minus one
	strobe_count_t count;
	// width captured at the trigger, zero already forced to one
	strobe_count_t width_q;
	// requested width with zero mapped to one
	strobe_count_t width_eff;

	assign width_eff = (strobe_width == '0) ? strobe_count_t'(1) : strobe_width;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			count   <= '0;
			width_q <= strobe_count_t'(1);
		end else begin
			case (state)
				st_idle: begin
					// timing taken here, later writes do not touch this pulse
					if (exp_rise) begin
						width_q <= width_eff;
						if (strobe_delay == '0) begin
							// no delay, straight into the pulse
							state <= st_active;
							count <= width_eff - strobe_count_t'(1);
						end else begin
							state <= st_delay;
							count <= strobe_delay - strobe_count_t'(1);
						end
					end
				end
				st_delay: begin
					if (count == '0) begin
						state <= st_active;
						count <= width_q - strobe_count_t'(1);
					end else begin
						count <= count - strobe_count_t'(1);
					end
				end
				st_active: begin
					if (count == '0) begin
						state <= st_idle;
					end else begin
						count <= count - strobe_count_t'(1);
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// outputs decoded from state
	// ----------------------------------------------------------

	// new edges are dropped while busy, so a flash never restarts
	assign strobe      = (state == st_active);
	assign strobe_busy = (state != st_idle);

endmodule

//--- line_source_select.sv
`timescale 1ns/1ps

`include "line_io_settings.svh"

module line_source_select (
	input  logic                      clk,
	input  logic                      rst_n,
	// candidate sources
	input  logic                      strobe,
	input  line_io_pkg::user_level_t  user_level,
	// per line routing and polarity
	input  line_io_pkg::line_source_t line_source1,
	input  line_io_pkg::line_source_t line_source2,
	input  line_io_pkg::line_source_t line_source3,
	input  line_io_pkg::line_vec_t    line_invert,
	// registered line drive
	output line_io_pkg::line_vec_t    line_out
);

	import line_io_pkg::*;

	// ----------------------------------------------------------
	// source decode
	// ----------------------------------------------------------

	// one code -> one bit, same table for every line
	function automatic logic select_source(
		input line_source_t code,
		input logic         strobe_in,
		input user_level_t  level
	);
		logic sel;
		case (code)
			3'd1:    sel = strobe_in;
			3'd2:    sel = level[0];
			3'd3:    sel = level[1];
			3'd4:    sel = level[2];
			// 0 and 5..7 fall back to user output 0
			default: sel = level[0];
		endcase
		return sel;
	endfunction

	// source codes gathered by line index
	line_source_t source [`LINE_COUNT];
	// selected and polarity corrected, before the register
	line_vec_t    line_next;

	assign source[0] = line_source1;
	assign source[1] = line_source2;
	assign source[2] = line_source3;

	always_comb begin
		for (int i = 0; i < `LINE_COUNT; i++) begin
			// inversion applied ahead of the output flop
			line_next[i] = select_source(source[i], strobe, user_level) ^ line_invert[i];
		end
	end

	// ----------------------------------------------------------
	// output register
	// ----------------------------------------------------------

	// one clk behind the selected source
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			line_out <= '0;
		end else begin
			line_out <= line_next;
		end
	end

endmodule

//--- line_io_top.sv
`timescale 1ns/1ps

module line_io_top (
	input  logic                   clk,
	input  logic                   rst_n,
	// apb slave
	input  line_io_pkg::apb_addr_t paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  line_io_pkg::apb_data_t pwdata,
	output line_io_pkg::apb_data_t prdata,
	output logic                   pready,
	output logic                   pslverr,
	// sensor exposure level
	input  logic                   exposure_start,
	// camera output lines
	output line_io_pkg::line_vec_t line_out
);

	import line_io_pkg::*;

	// ----------------------------------------------------------
	// internal wiring
	// ----------------------------------------------------------

	// configuration from the register file
	user_level_t   user_level;
	line_source_t  line_source1;
	line_source_t  line_source2;
	line_source_t  line_source3;
	line_vec_t     line_invert;
	strobe_count_t strobe_delay;
	strobe_count_t strobe_width;
	// flash pulse and its activity flag
	logic          strobe;
	logic          strobe_busy;

	// ----------------------------------------------------------
	// apb register file
	// ----------------------------------------------------------

	line_io_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		// status readback
		.strobe_busy  (strobe_busy),
		.line_out     (line_out),
		.user_level   (user_level),
		.line_source1 (line_source1),
		.line_source2 (line_source2),
		.line_source3 (line_source3),
		.line_invert  (line_invert),
		.strobe_delay (strobe_delay),
		.strobe_width (strobe_width)
	);

	// ----------------------------------------------------------
	// flash strobe from exposure start
	// ----------------------------------------------------------

	strobe_pulse_gen u_strobe (
		.clk            (clk),
		.rst_n          (rst_n),
		.exposure_start (exposure_start),
		.strobe_delay   (strobe_delay),
		.strobe_width   (strobe_width),
		.strobe         (strobe),
		.strobe_busy    (strobe_busy)
	);

	// ----------------------------------------------------------
	// line routing and polarity
	// ----------------------------------------------------------

	line_source_select u_select (
		.clk          (clk),
		.rst_n        (rst_n),
		.strobe       (strobe),
		.user_level   (user_level),
		.line_source1 (line_source1),
		.line_source2 (line_source2),
		.line_source3 (line_source3),
		.line_invert  (line_invert),
		.line_out     (line_out)
	);

endmodule

//--- line_io_props.sv
`timescale 1ns/1ps

module line_io_props (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pslverr,
	input  logic                       strobe,
	input  line_io_pkg::line_vec_t     line_out,
	// strobe sequencer internals
	input  line_io_pkg::strobe_state_t strobe_state,
	input  line_io_pkg::strobe_count_t width_q,
	input  logic                       exp_rise
);

	import line_io_pkg::*;

	// cycles strobe has been high in the running pulse
	strobe_count_t high_count;
	// failed properties so far, polled by the testbench
	int            fail_count = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			high_count <= '0;
		end else if (strobe) begin
			high_count <= high_count + strobe_count_t'(1);
		end else begin
			high_count <= '0;
		end
	end

	// ----------------------------------------------------------
	// properties
	// ----------------------------------------------------------

	// slave error only in an access phase that follows its setup phase
	a_pslverr_access: assert property (@(posedge clk)
		pslverr |-> (psel && penable && $past(psel && !penable)))
		else begin
			$error("pslverr high outside an apb access phase");
			fail_count++;
		end

	// pulse entered only from a finished delay or a fresh trigger
	a_strobe_state: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(strobe) |-> (($past(strobe_state) == st_delay) || $past(exp_rise)))
		else begin
			$error("strobe rose without a trigger or a delay phase");
			fail_count++;
		end

	// pulse length equals the width latched at the trigger
	a_strobe_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(strobe) |-> (high_count == width_q))
		else begin
			$error("strobe pulse length differs from latched width");
			fail_count++;
		end

	a_reset_values: assert property (@(posedge clk)
		$rose(rst_n) |-> ((line_out == '0) && !strobe))
		else begin
			$error("line_out or strobe not cleared by reset");
			fail_count++;
		end

endmodule

bind line_io_top line_io_props props (
	.clk          (clk),
	.rst_n        (rst_n),
	.psel         (psel),
	.penable      (penable),
	.pslverr      (pslverr),
	.strobe       (strobe),
	.line_out     (line_out),
	.strobe_state (u_strobe.state),
	.width_q      (u_strobe.width_q),
	.exp_rise     (u_strobe.exp_rise)
);

//--- line_io_tb.sv
`timescale 1ns/1ps

`include "line_io_settings.svh"

module line_io_tb;

	import line_io_pkg::*;

	// about twice the summed length of all test phases
	localparam int max_cycles = 4000;

	// ----------------------------------------------------------
	// register map of the i/o block
	// ----------------------------------------------------------

	localparam apb_addr_t addr_user_level   = 8'h00;
	localparam apb_addr_t addr_line_source1 = 8'h04;
	localparam apb_addr_t addr_line_source2 = 8'h08;
	localparam apb_addr_t addr_line_source3 = 8'h0C;
	localparam apb_addr_t addr_line_invert  = 8'h10;
	localparam apb_addr_t addr_strobe_delay = 8'h14;
	localparam apb_addr_t addr_strobe_width = 8'h18;
	localparam apb_addr_t addr_status       = 8'h1C;

	logic      clk;
	logic      rst_n;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      exposure_start;
	line_vec_t line_out;

	// reference model of the configuration registers
	user_level_t   m_user_level;
	line_source_t  m_src [`LINE_COUNT];
	line_vec_t     m_invert;
	strobe_count_t m_delay;
	strobe_count_t m_width;

	logic [31:0] rng_state = 32'd2;
	// posedges seen since time 0
	int          cycle = 0;

	line_io_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.paddr          (paddr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.exposure_start (exposure_start),
		.line_out       (line_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("timeout: test did not finish within %0d clock cycles", max_cycles);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	// bound property failures end the run at once
	always @(negedge clk) begin
		if (dut.props.fail_count != 0) begin
			$display("a bound protocol or strobe assertion failed");
			$display(">>> FAIL");
			$fatal(1, "assertion failure");
		end
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// word aligned, 0x00..0x1C
	function automatic logic is_mapped(input apb_addr_t addr);
		return (addr <= addr_status) && (addr[1:0] == 2'b00);
	endfunction

	// implemented bits of each register
	function automatic apb_data_t reg_mask(input apb_addr_t addr);
		if (addr == addr_strobe_delay || addr == addr_strobe_width) begin
			return apb_data_t'((64'd1 << `STROBE_COUNT_WIDTH) - 64'd1);
		end
		return apb_data_t'(3'h7);
	endfunction

	function automatic apb_data_t model_read(input apb_addr_t addr);
		case (addr)
			addr_user_level:   return apb_data_t'(m_user_level);
			addr_line_source1: return apb_data_t'(m_src[0]);
			addr_line_source2: return apb_data_t'(m_src[1]);
			addr_line_source3: return apb_data_t'(m_src[2]);
			addr_line_invert:  return apb_data_t'(m_invert);
			addr_strobe_delay: return apb_data_t'(m_delay);
			addr_strobe_width: return apb_data_t'(m_width);
			default:           return '0;
		endcase
	endfunction

	function automatic void model_write(input apb_addr_t addr, input apb_data_t data);
		case (addr)
			addr_user_level:   m_user_level = user_level_t'(data);
			addr_line_source1: m_src[0] = line_source_t'(data);
			addr_line_source2: m_src[1] = line_source_t'(data);
			addr_line_source3: m_src[2] = line_source_t'(data);
			addr_line_invert:  m_invert = line_vec_t'(data);
			addr_strobe_delay: m_delay = strobe_count_t'(data);
			addr_strobe_width: m_width = strobe_count_t'(data);
			default: ;
		endcase
	endfunction

	// predicted line drive for a given strobe level
	function automatic line_vec_t expected_lines(input logic strobe_level);
		line_vec_t v;
		logic      bit_v;
		for (int i = 0; i < `LINE_COUNT; i++) begin
			if (m_src[i] == 3'd1) begin
				bit_v = strobe_level;
			end else if (m_src[i] >= 3'd2 && m_src[i] <= 3'd4) begin
				bit_v = m_user_level[m_src[i] - 3'd2];
			end else begin
				// unused codes act as user output 0
				bit_v = m_user_level[0];
			end
			v[i] = bit_v ^ m_invert[i];
		end
		return v;
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "first mismatch");
		end
	endtask

	// ----------------------------------------------------------
	// apb master, entered and left at a falling edge
	// ----------------------------------------------------------

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		paddr   = addr;
		pwrite  = 1'b1;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#2;
		check_equal(pslverr, !is_mapped(addr), "pslverr in write access phase");
		// zero wait states
		check_equal(pready, 1'b1, "pready in write access phase");
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		model_write(addr, data);
	endtask

	// at_cycle is the last posedge before the sample
	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output int at_cycle);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#2;
		data     = prdata;
		at_cycle = cycle;
		check_equal(pslverr, !is_mapped(addr), "pslverr in read access phase");
		check_equal(pready, 1'b1, "pready in read access phase");
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_registers();
		apb_data_t rdata;
		int        at;
		for (int a = 0; a <= int'(addr_strobe_width); a += 4) begin
			apb_read(apb_addr_t'(a), rdata, at);
			check_equal(rdata, model_read(apb_addr_t'(a)), "register content");
		end
	endtask

	// ----------------------------------------------------------
	// strobe pulse tracking
	// ----------------------------------------------------------

	// k is the edge that samples exposure_start high
	task automatic watch_pulse(input int k, input int d, input int w);
		int   weff;
		int   stop;
		logic s;
		weff = (w == 0) ? 1 : w;
		stop = k + d + weff + 4;
		while (cycle < stop) begin
			@(negedge clk);
			s = (cycle >= k + 2 + d) && (cycle < k + 2 + d + weff);
			check_equal(line_out, expected_lines(s), "line_out around strobe pulse");
		end
	endtask

	task automatic run_pulse(input int d, input int w);
		int k;
		apb_write(addr_strobe_delay, apb_data_t'(d));
		apb_write(addr_strobe_width, apb_data_t'(w));
		exposure_start = 1'b1;
		k = cycle + 1;
		watch_pulse(k, d, w);
		exposure_start = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	// retrigger and timing writes while a pulse runs
	task automatic disturb_pulse(input int k, input int d, input int w);
		apb_data_t rdata;
		int        at;
		int        weff;
		logic      busy;
		logic      s;
		weff = (w == 0) ? 1 : w;
		@(negedge clk);
		exposure_start = 1'b0;
		@(negedge clk);
		exposure_start = 1'b1;
		@(negedge clk);
		exposure_start = 1'b0;
		apb_write(addr_strobe_delay, next_rand() % 4);
		apb_write(addr_strobe_width, 1 + next_rand() % 4);
		apb_read(addr_status, rdata, at);
		busy = (at >= k + 1) && (at < k + 1 + d + weff);
		s    = (at >= k + 2 + d) && (at < k + 2 + d + weff);
		check_equal(rdata, {28'd0, expected_lines(s), busy}, "status during pulse");
	endtask

	// ----------------------------------------------------------
	// test phases
	// ----------------------------------------------------------

	task automatic test_register_access();
		apb_data_t data;
		apb_data_t rdata;
		apb_addr_t addr;
		int        at;
		// reset values first
		check_equal(line_out, 0, "line_out after reset");
		check_registers();
		for (int round = 0; round < 3; round++) begin
			for (int a = 0; a <= int'(addr_strobe_width); a += 4) begin
				data = next_rand();
				apb_write(apb_addr_t'(a), data);
				apb_read(apb_addr_t'(a), rdata, at);
				check_equal(rdata, data & reg_mask(apb_addr_t'(a)), "register readback");
			end
			// read-only status
			apb_write(addr_status, next_rand());
			apb_read(addr_status, rdata, at);
			check_equal(rdata, {28'd0, expected_lines(1'b0), 1'b0}, "status after write");
			check_registers();
		end
		for (int n = 0; n < 8; n++) begin
			addr = apb_addr_t'(next_rand());
			while (is_mapped(addr)) begin
				addr = apb_addr_t'(next_rand());
			end
			apb_write(addr, next_rand());
			apb_read(addr, rdata, at);
			check_equal(rdata, 0, "read of unmapped address");
			check_registers();
		end
	endtask

	task automatic test_source_select();
		apb_write(addr_line_invert, 0);
		for (int n = 0; n < 40; n++) begin
			apb_write(addr_user_level, next_rand());
			apb_write(addr_line_source1, next_rand() & 32'h7);
			apb_write(addr_line_source2, next_rand() & 32'h7);
			apb_write(addr_line_source3, next_rand() & 32'h7);
			@(negedge clk);
			check_equal(line_out, expected_lines(1'b0), "line_out for selected sources");
		end
	endtask

	task automatic test_inversion();
		for (int n = 0; n < 20; n++) begin
			apb_write(addr_user_level, next_rand());
			apb_write(addr_line_invert, next_rand());
			apb_write(addr_line_source1, next_rand() & 32'h7);
			apb_write(addr_line_source2, next_rand() & 32'h7);
			apb_write(addr_line_source3, next_rand() & 32'h7);
			@(negedge clk);
			check_equal(line_out, expected_lines(1'b0), "line_out with inversion");
		end
		// inverted strobe lines idle high
		for (int n = 0; n < 4; n++) begin
			apb_write(addr_line_source1, 1);
			apb_write(addr_line_source2, next_rand() & 32'h7);
			apb_write(addr_line_source3, 1);
			apb_write(addr_line_invert, next_rand());
			run_pulse(next_rand() % 6, next_rand() % 7);
		end
	endtask

	task automatic test_strobe_timing();
		int d;
		int w;
		apb_write(addr_line_invert, 0);
		apb_write(addr_line_source1, 1);
		apb_write(addr_line_source2, 1);
		apb_write(addr_line_source3, 1);
		for (int n = 0; n < 12; n++) begin
			d = next_rand() % 21;
			w = next_rand() % 21;
			// corner cases: no delay, zero width
			if (n == 0) begin
				d = 0;
			end
			if (n == 1) begin
				w = 0;
			end
			run_pulse(d, w);
		end
	endtask

	task automatic test_pulse_protection();
		apb_data_t rdata;
		int        at;
		int        d;
		int        w;
		int        k;
		for (int n = 0; n < 3; n++) begin
			d = next_rand() % 5;
			w = 14 + next_rand() % 7;
			apb_write(addr_strobe_delay, d);
			apb_write(addr_strobe_width, w);
			exposure_start = 1'b1;
			k = cycle + 1;
			fork
				watch_pulse(k, d, w);
				disturb_pulse(k, d, w);
			join
			apb_read(addr_status, rdata, at);
			check_equal(rdata, {28'd0, expected_lines(1'b0), 1'b0}, "status after pulse");
			// timing written mid pulse applies to the next one
			run_pulse(m_delay, m_width);
		end
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------

	initial begin
		rst_n          = 1'b0;
		paddr          = '0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		pwdata         = '0;
		exposure_start = 1'b0;
		m_user_level   = '0;
		m_src[0]       = '0;
		m_src[1]       = '0;
		m_src[2]       = '0;
		m_invert       = '0;
		m_delay        = '0;
		m_width        = strobe_count_t'(1);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_register_access();
		test_source_select();
		test_inversion();
		test_strobe_timing();
		test_pulse_protection();
		if (dut.props.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

//--- verilog.f
+incdir+.
line_io_pkg.sv
line_io_regs.sv
strobe_pulse_gen.sv
line_source_select.sv
line_io_top.sv
line_io_props.sv
line_io_tb.sv
